// File: bench/lc3b_properties.sv
`timescale 1ns/100ps
`default_nettype none

module lc3b_properties (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   instr_valid,
    input lc3b_types::exec_result result
);

    // fixed two cycle latency.
    assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> ##2 result.result_valid)
        else $error("result_valid did not follow instr_valid");

    assert property (@(posedge clk) disable iff (!rst_n)
        result.result_valid |-> $past(instr_valid, 2))
        else $error("result_valid without an issue two cycles before");

    assert property (@(posedge clk) !(result.mem_read && result.mem_write))
        else $error("read and write requested together");

    assert property (@(posedge clk) $rose(rst_n) |->
        !result.result_valid && !result.wb_enable && !result.mem_read &&
        !result.mem_write && !result.pc_redirect)
        else $error("outputs active right after reset");

endmodule

bind lc3b_decode_execute lc3b_properties u_properties (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .result      (result)
);

`default_nettype wire

// File: bench/tb_lc3b_decode_execute.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lc3b_decode_execute;

    localparam int test_instrs = 46 + 20 + 30 + 47 + 4;
    localparam int cycle_limit = 2 * test_instrs + 8 + 50; // gaps, reset and slack.

    logic                   clk;
    logic                   rst_n;
    logic                   instr_valid;
    lc3b_types::lc3b_word   instr;
    lc3b_types::lc3b_word   pc;
    lc3b_types::exec_result result;

    int                     seed = 32'h6ef4;
    int                     cycle = 0;
    int                     errors = 0;
    int                     checked = 0;
    lc3b_types::lc3b_word   shadow_regs [8];
    lc3b_types::lc3b_cc     shadow_cc;
    lc3b_types::exec_result exp_q [$];
    int                     due_q [$];

    lc3b_decode_execute uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .result      (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    always @(posedge clk) begin
        if (cycle >= cycle_limit) begin
            $display("run stopped after %0d cycles with results still outstanding", cycle);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic lc3b_types::lc3b_word sext(input lc3b_types::lc3b_word v, input int bits);
        lc3b_types::lc3b_word t;
        t = v << (16 - bits);
        return lc3b_types::lc3b_word'($signed(t) >>> (16 - bits));
    endfunction

    function automatic void commit(inout lc3b_types::exec_result e, input lc3b_types::lc3b_reg r,
                                   input lc3b_types::lc3b_word v, input logic set_cc);
        e.wb_enable = 1'b1;
        e.wb_reg = r;
        e.wb_data = v;
        shadow_regs[r] = v;
        if (set_cc) begin
            shadow_cc = v[15] ? 3'b100 : ((v == 16'h0) ? 3'b010 : 3'b001);
        end
    endfunction

    // sequential model of one instruction.
    function automatic lc3b_types::exec_result model_instr(input lc3b_types::lc3b_word ins,
                                                           input lc3b_types::lc3b_word p);
        lc3b_types::exec_result e;
        logic [3:0]             op;
        lc3b_types::lc3b_word   a;
        lc3b_types::lc3b_word   b;
        logic [3:0]             amt;
        e = '0;
        e.result_valid = 1'b1;
        op = ins[15:12];
        a = shadow_regs[ins[8:6]];
        amt = ins[3:0];
        b = ins[5] ? sext(ins, 5) : shadow_regs[ins[2:0]];
        case (op)
            4'b0001: commit(e, ins[11:9], a + b, 1'b1);
            4'b0101: commit(e, ins[11:9], a & b, 1'b1);
            4'b1001: commit(e, ins[11:9], ~a, 1'b1);
            4'b1101: begin
                if (!ins[4]) begin
                    commit(e, ins[11:9], a << amt, 1'b1);
                end else if (!ins[5]) begin
                    commit(e, ins[11:9], a >> amt, 1'b1);
                end else begin
                    commit(e, ins[11:9], lc3b_types::lc3b_word'($signed(a) >>> amt), 1'b1);
                end
            end
            4'b0110, 4'b1010, 4'b0010, 4'b0111, 4'b1011, 4'b0011: begin
                e.mem_read = !op[0];
                e.mem_write = op[0];
                e.mem_byte = (op[3:1] == 3'b001);
                e.mem_addr = a + (e.mem_byte ? sext(ins, 6) : (sext(ins, 6) << 1));
                e.mem_wdata = shadow_regs[ins[11:9]];
            end
            4'b1110: commit(e, ins[11:9], p + (sext(ins, 9) << 1), 1'b0);
            4'b0000: begin
                e.pc_redirect = |(ins[11:9] & shadow_cc);
                e.pc_target = p + (sext(ins, 9) << 1);
            end
            4'b1100: begin
                e.pc_redirect = 1'b1;
                e.pc_target = a;
            end
            4'b0100: begin
                e.pc_redirect = 1'b1;
                e.pc_target = ins[11] ? p + (sext(ins, 11) << 1) : a; // old r7 for jsrr r7.
                commit(e, 3'd7, p, 1'b0);
            end
            4'b1111: begin
                e.pc_redirect = 1'b1;
                e.mem_read = 1'b1;
                e.pc_target = {7'b0, ins[7:0], 1'b0};
                e.mem_addr = e.pc_target;
                commit(e, 3'd7, p, 1'b0);
            end
            default: begin
            end
        endcase
        e.cc = shadow_cc;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        checked++;
        assert (exp === act) else begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_result(input lc3b_types::exec_result e);
        check_value("wb_enable", 16'(e.wb_enable), 16'(result.wb_enable));
        check_value("mem_read", 16'(e.mem_read), 16'(result.mem_read));
        check_value("mem_write", 16'(e.mem_write), 16'(result.mem_write));
        check_value("pc_redirect", 16'(e.pc_redirect), 16'(result.pc_redirect));
        check_value("cc", 16'(e.cc), 16'(result.cc));
        if (e.wb_enable) begin
            check_value("wb_reg", 16'(e.wb_reg), 16'(result.wb_reg));
            check_value("wb_data", e.wb_data, result.wb_data);
        end
        if (e.mem_read || e.mem_write) begin
            check_value("mem_addr", e.mem_addr, result.mem_addr);
            check_value("mem_byte", 16'(e.mem_byte), 16'(result.mem_byte));
        end
        if (e.mem_write) begin
            check_value("mem_wdata", e.mem_wdata, result.mem_wdata);
        end
        if (e.pc_redirect) begin
            check_value("pc_target", e.pc_target, result.pc_target);
        end
    endtask

    // results are sampled half a cycle after the edge that registers them.
    always @(negedge clk) begin
        if (rst_n) begin
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                assert (result.result_valid) else begin
                    $display("result missing two cycles after issue at %0t", $time);
                    errors++;
                end
                if (result.result_valid) begin
                    compare_result(exp_q[0]);
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                assert (!result.result_valid) else begin
                    $display("result valid at %0t with no instruction due", $time);
                    errors++;
                end
            end
        end
    end

    task automatic issue(input lc3b_types::lc3b_word ins, input lc3b_types::lc3b_word p);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr <= ins;
        pc <= p;
        exp_q.push_back(model_instr(ins, p));
        due_q.push_back(cycle + 3);
    endtask

    task automatic idle();
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        idle();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        $display("test %s done with %0d errors", name, errors - errors_before);
    endtask

    function automatic lc3b_types::lc3b_word rand_pc();
        return lc3b_types::lc3b_word'($random(seed)) & 16'hfffe;
    endfunction

    function automatic lc3b_types::lc3b_word rand_alu_instr();
        lc3b_types::lc3b_word ins;
        logic [1:0]           sel;
        ins = lc3b_types::lc3b_word'($random(seed));
        sel = 2'($random(seed));
        case (sel)
            2'd0: ins[15:12] = 4'b0001;
            2'd1: ins[15:12] = 4'b0101;
            2'd2: ins = {4'b1001, ins[11:6], 6'h3f};
            default: ins[15:12] = 4'b1101;
        endcase
        return ins;
    endfunction

    initial begin
        int                   start;
        lc3b_types::lc3b_word ins;
        logic [3:0]           mem_ops [6];
        logic [2:0]           prev;
        mem_ops = '{4'b0110, 4'b1010, 4'b0010, 4'b0111, 4'b1011, 4'b0011};
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        for (int i = 0; i < 8; i++) begin
            shadow_regs[i] = '0;
        end
        shadow_cc = 3'b010;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);

        start = errors;
        for (int r = 1; r < 7; r++) begin
            issue({4'b0001, 3'(r), 3'd0, 1'b1, 5'($random(seed))}, rand_pc());
        end
        for (int i = 0; i < 40; i++) begin
            issue(rand_alu_instr(), rand_pc());
        end
        finish_test("arith", start);

        start = errors;
        prev = 3'd1;
        for (int i = 0; i < 20; i++) begin
            ins = rand_alu_instr();
            ins[8:6] = prev;
            if (i % 3 == 0) begin
                ins[2:0] = prev;
            end
            prev = ins[11:9];
            issue(ins, rand_pc());
        end
        finish_test("chain", start);

        start = errors;
        for (int i = 0; i < 30; i++) begin
            ins = lc3b_types::lc3b_word'($random(seed));
            ins[15:12] = mem_ops[$unsigned($random(seed)) % 6];
            issue(ins, rand_pc());
        end
        finish_test("memory", start);

        start = errors;
        for (int c = 0; c < 3; c++) begin
            issue({4'b0001, 3'd1, 3'd0, 1'b1, (c == 0) ? 5'h1d : ((c == 1) ? 5'h00 : 5'h05)},
                  rand_pc());
            for (int m = 0; m < 8; m++) begin
                issue({4'b0000, 3'(m), 9'($random(seed))}, rand_pc());
                idle();
            end
        end
        for (int i = 0; i < 4; i++) begin
            issue({4'b1100, 3'd0, 3'($random(seed)), 6'd0}, rand_pc());
            idle();
            issue({4'b0100, 1'b1, 11'($random(seed))}, rand_pc());
            idle();
            issue({4'b0100, 3'd0, 3'($random(seed)), 6'd0}, rand_pc()); // jsrr.
            idle();
            issue({4'b1110, 3'($random(seed)), 9'($random(seed))}, rand_pc());
            issue({4'b1111, 4'd0, 8'($random(seed))}, rand_pc());
            idle();
        end
        finish_test("control", start);

        start = errors;
        for (int i = 0; i < 4; i++) begin
            issue({4'b1000, 12'($random(seed))}, rand_pc());
        end
        finish_test("undefined", start);

        repeat (4) @(posedge clk);
        $display("%0d checks, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: common/lc3b_types.sv
`default_nettype none

package lc3b_types;

    localparam int word_width = 16;
    localparam int reg_count = 8;

    // addr2 mux encodings.
    localparam logic [1:0] addr2_zero = 2'b00;
    localparam logic [1:0] addr2_off6 = 2'b01;
    localparam logic [1:0] addr2_off9 = 2'b10;
    localparam logic [1:0] addr2_off11 = 2'b11;

    typedef logic [word_width-1:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;
    typedef logic [2:0] lc3b_cc; // n, z, p.

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000, // not decoded here.
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_ops;

    typedef enum logic [1:0] {
        rf_src_alu,
        rf_src_mem, // load return, written elsewhere.
        rf_src_addr,
        rf_src_pc
    } rf_src;

    typedef struct packed {
        lc3b_opcode opcode;
        alu_ops aluop;
        rf_src rf_src;
        logic load_regfile;
        logic load_cc;
        logic sr2mux_sel;   // immediate operand.
        logic addr1mux_sel; // base register instead of pc.
        logic [1:0] addr2mux_sel;
        logic lshf_enable;
        logic mem_read;
        logic mem_write;
        logic mem_byte;
        logic redirect;     // jump or branch candidate.
        logic destmux_sel;  // write r7.
        logic sr1_needed;
    } lc3b_control_word;

    typedef struct packed {
        logic result_valid;
        logic wb_enable;
        lc3b_reg wb_reg;
        lc3b_word wb_data;
        logic mem_read;
        logic mem_write;
        logic mem_byte;
        lc3b_word mem_addr;
        lc3b_word mem_wdata;
        logic pc_redirect;
        lc3b_word pc_target;
        lc3b_cc cc;
    } exec_result;

endpackage

`default_nettype wire

// File: execute/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  lc3b_types::alu_ops   aluop,
    input  lc3b_types::lc3b_word a,
    input  lc3b_types::lc3b_word b,
    output lc3b_types::lc3b_word f
);

    logic [3:0] shamt;

    assign shamt = b[3:0];

    always_comb begin
        case (aluop)
            lc3b_types::alu_add:  f = a + b;
            lc3b_types::alu_and:  f = a & b;
            lc3b_types::alu_not:  f = ~a;
            lc3b_types::alu_sll:  f = a << shamt;
            lc3b_types::alu_srl:  f = a >> shamt;
            lc3b_types::alu_sra:  f = $signed(a) >>> shamt; // keeps sign.
            default:              f = a;
        endcase
    end

endmodule

`default_nettype wire

// File: execute/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         instr_valid,
    input  lc3b_types::lc3b_control_word ctrl,
    input  lc3b_types::lc3b_word         instr,
    input  lc3b_types::lc3b_word         pc,
    input  lc3b_types::lc3b_word         sr1_data,
    input  lc3b_types::lc3b_word         sr2_data,
    output logic                         wr_enable,
    output lc3b_types::lc3b_reg          wr_reg,
    output lc3b_types::lc3b_word         wr_data,
    output lc3b_types::exec_result       result
);

    logic                         v_q;
    lc3b_types::lc3b_control_word ctrl_q;
    lc3b_types::lc3b_word         instr_q;
    lc3b_types::lc3b_word         pc_q;
    lc3b_types::lc3b_word         sr1_q;
    lc3b_types::lc3b_word         sr2_q;
    lc3b_types::lc3b_cc           cc_q;
    lc3b_types::lc3b_cc           cc_new;
    lc3b_types::lc3b_word         imm;
    lc3b_types::lc3b_word         alu_a;
    lc3b_types::lc3b_word         alu_b;
    lc3b_types::lc3b_word         alu_f;
    lc3b_types::lc3b_word         offset;
    lc3b_types::lc3b_word         base;
    lc3b_types::lc3b_word         addr;
    lc3b_types::lc3b_word         target;
    logic                         br_taken;
    logic                         cc_load;
    lc3b_types::exec_result       nxt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v_q <= 1'b0;
        end else begin
            v_q <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        ctrl_q <= ctrl;
        instr_q <= instr;
        pc_q <= pc;
        sr1_q <= sr1_data;
        sr2_q <= sr2_data;
    end

    assign imm = (ctrl_q.opcode == lc3b_types::op_shf) ? {{12{instr_q[3]}}, instr_q[3:0]}
                                                       : {{11{instr_q[4]}}, instr_q[4:0]};
    assign alu_a = ctrl_q.sr1_needed ? sr1_q : '0;
    assign alu_b = ctrl_q.sr2mux_sel ? imm : sr2_q;

    alu u_alu (
        .aluop (ctrl_q.aluop),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_f)
    );

    always_comb begin
        case (ctrl_q.addr2mux_sel)
            lc3b_types::addr2_off6:  offset = {{10{instr_q[5]}}, instr_q[5:0]};
            lc3b_types::addr2_off9:  offset = {{7{instr_q[8]}}, instr_q[8:0]};
            lc3b_types::addr2_off11: offset = {{5{instr_q[10]}}, instr_q[10:0]};
            default:                 offset = '0;
        endcase
    end

    assign base = ctrl_q.addr1mux_sel ? sr1_q : pc_q;
    assign addr = base + (ctrl_q.lshf_enable ? (offset << 1) : offset);
    // trap vector table sits at the bottom of memory.
    assign target = (ctrl_q.opcode == lc3b_types::op_trap) ? {7'b0, instr_q[7:0], 1'b0} : addr;
    assign br_taken = |(instr_q[11:9] & cc_q);

    assign wr_enable = v_q && ctrl_q.load_regfile && (ctrl_q.rf_src != lc3b_types::rf_src_mem);
    assign wr_reg = ctrl_q.destmux_sel ? 3'd7 : instr_q[11:9];

    always_comb begin
        case (ctrl_q.rf_src)
            lc3b_types::rf_src_addr: wr_data = addr;
            lc3b_types::rf_src_pc:   wr_data = pc_q; // link.
            default:                 wr_data = alu_f;
        endcase
    end

    assign cc_new = {wr_data[15], wr_data == '0, !wr_data[15] && (wr_data != '0)};
    assign cc_load = wr_enable && ctrl_q.load_cc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cc_q <= 3'b010;
        end else if (cc_load) begin
            cc_q <= cc_new;
        end
    end

    always_comb begin
        nxt = '0;
        nxt.result_valid = v_q;
        nxt.wb_enable = wr_enable;
        nxt.wb_reg = wr_reg;
        nxt.wb_data = wr_data;
        nxt.mem_read = v_q && ctrl_q.mem_read;
        nxt.mem_write = v_q && ctrl_q.mem_write;
        nxt.mem_byte = ctrl_q.mem_byte;
        nxt.mem_addr = target;
        nxt.mem_wdata = sr2_q;
        nxt.pc_redirect = v_q && ctrl_q.redirect &&
                          ((ctrl_q.opcode != lc3b_types::op_br) || br_taken);
        nxt.pc_target = target;
        nxt.cc = cc_load ? cc_new : cc_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result <= nxt;
        end
    end

endmodule

`default_nettype wire

// File: lc3b_decode_execute.f
common/lc3b_types.sv
verilog/control_rom.sv
verilog/regfile.sv
execute/alu.sv
execute/execute_stage.sv
verilog/lc3b_decode_execute.sv
bench/lc3b_properties.sv
bench/tb_lc3b_decode_execute.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run; success only if the pass line is printed.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lc3b_decode_execute -f lc3b_decode_execute.f -o sim_lc3b &&
./obj_dir/sim_lc3b | tee /dev/stderr | grep -qF '** PASS **' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: verilog/control_rom.sv
`timescale 1ns/100ps
`default_nettype none

module control_rom (
    input  lc3b_types::lc3b_opcode       opcode,
    input  logic                         imm_check, // also picks srl or sra.
    input  logic                         jsr_check,
    input  logic                         rshf_check,
    output lc3b_types::lc3b_control_word ctrl
);

    always_comb begin
        ctrl = '0;
        ctrl.opcode = opcode;
        ctrl.aluop = lc3b_types::alu_pass;
        ctrl.rf_src = lc3b_types::rf_src_alu;
        ctrl.addr2mux_sel = lc3b_types::addr2_zero;
        ctrl.lshf_enable = 1'b1; // word offsets.

        case (opcode)
            lc3b_types::op_add: begin
                ctrl.sr1_needed = 1'b1;
                ctrl.aluop = lc3b_types::alu_add;
                ctrl.sr2mux_sel = imm_check;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end

            lc3b_types::op_and: begin
                ctrl.sr1_needed = 1'b1;
                ctrl.aluop = lc3b_types::alu_and;
                ctrl.sr2mux_sel = imm_check;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end

            lc3b_types::op_not: begin
                ctrl.sr1_needed = 1'b1;
                ctrl.aluop = lc3b_types::alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end

            lc3b_types::op_shf: begin
                ctrl.sr1_needed = 1'b1;
                ctrl.sr2mux_sel = 1'b1; // amount is imm4.
                if (!rshf_check) begin
                    ctrl.aluop = lc3b_types::alu_sll;
                end else if (!imm_check) begin
                    ctrl.aluop = lc3b_types::alu_srl;
                end else begin
                    ctrl.aluop = lc3b_types::alu_sra;
                end
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end

            // ldi only issues its first access for now.
            lc3b_types::op_ldr, lc3b_types::op_ldi: begin
                ctrl.sr1_needed = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.rf_src = lc3b_types::rf_src_mem;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.addr1mux_sel = 1'b1;
                ctrl.addr2mux_sel = lc3b_types::addr2_off6;
            end

            lc3b_types::op_ldb: begin
                ctrl.sr1_needed = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.mem_byte = 1'b1;
                ctrl.lshf_enable = 1'b0; // byte offset.
                ctrl.rf_src = lc3b_types::rf_src_mem;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.addr1mux_sel = 1'b1;
                ctrl.addr2mux_sel = lc3b_types::addr2_off6;
            end

            lc3b_types::op_str, lc3b_types::op_sti: begin
                ctrl.sr1_needed = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.addr1mux_sel = 1'b1;
                ctrl.addr2mux_sel = lc3b_types::addr2_off6;
            end

            lc3b_types::op_stb: begin
                ctrl.sr1_needed = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.mem_byte = 1'b1;
                ctrl.lshf_enable = 1'b0;
                ctrl.addr1mux_sel = 1'b1;
                ctrl.addr2mux_sel = lc3b_types::addr2_off6;
            end

            lc3b_types::op_lea: begin
                ctrl.addr2mux_sel = lc3b_types::addr2_off9;
                ctrl.rf_src = lc3b_types::rf_src_addr;
                ctrl.load_regfile = 1'b1; // cc untouched.
            end

            lc3b_types::op_br: begin
                ctrl.redirect = 1'b1;
                ctrl.addr2mux_sel = lc3b_types::addr2_off9;
            end

            lc3b_types::op_jmp: begin
                ctrl.sr1_needed = 1'b1;
                ctrl.redirect = 1'b1;
                ctrl.addr1mux_sel = 1'b1;
            end

            lc3b_types::op_jsr: begin
                ctrl.redirect = 1'b1;
                ctrl.destmux_sel = 1'b1;
                ctrl.rf_src = lc3b_types::rf_src_pc;
                ctrl.load_regfile = 1'b1;
                if (jsr_check) begin
                    ctrl.addr2mux_sel = lc3b_types::addr2_off11;
                end else begin
                    ctrl.sr1_needed = 1'b1; // jsrr.
                    ctrl.addr1mux_sel = 1'b1;
                end
            end

            lc3b_types::op_trap: begin
                ctrl.redirect = 1'b1;
                ctrl.mem_read = 1'b1; // vector table read.
                ctrl.destmux_sel = 1'b1;
                ctrl.rf_src = lc3b_types::rf_src_pc;
                ctrl.load_regfile = 1'b1;
            end

            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/lc3b_decode_execute.sv
`timescale 1ns/100ps
`default_nettype none

module lc3b_decode_execute (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  lc3b_types::lc3b_word   instr,
    input  lc3b_types::lc3b_word   pc,
    output lc3b_types::exec_result result
);

    lc3b_types::lc3b_opcode       opcode;
    lc3b_types::lc3b_control_word ctrl;
    lc3b_types::lc3b_reg          rd_reg_b;
    lc3b_types::lc3b_word         sr1_data;
    lc3b_types::lc3b_word         sr2_data;
    logic                         wr_enable;
    lc3b_types::lc3b_reg          wr_reg;
    lc3b_types::lc3b_word         wr_data;

    assign opcode = lc3b_types::lc3b_opcode'(instr[15:12]);
    assign rd_reg_b = ctrl.mem_write ? instr[11:9] : instr[2:0]; // store data source.

    control_rom u_control_rom (
        .opcode     (opcode),
        .imm_check  (instr[5]),
        .jsr_check  (instr[11]),
        .rshf_check (instr[4]),
        .ctrl       (ctrl)
    );

    regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_reg_a  (instr[8:6]),
        .rd_reg_b  (rd_reg_b),
        .wr_reg    (wr_reg),
        .wr_enable (wr_enable),
        .wr_data   (wr_data),
        .rd_data_a (sr1_data),
        .rd_data_b (sr2_data)
    );

    execute_stage u_execute_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .ctrl        (ctrl),
        .instr       (instr),
        .pc          (pc),
        .sr1_data    (sr1_data),
        .sr2_data    (sr2_data),
        .wr_enable   (wr_enable),
        .wr_reg      (wr_reg),
        .wr_data     (wr_data),
        .result      (result)
    );

endmodule

`default_nettype wire

// File: verilog/regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  lc3b_types::lc3b_reg rd_reg_a,
    input  lc3b_types::lc3b_reg rd_reg_b,
    input  lc3b_types::lc3b_reg wr_reg,
    input  logic                wr_enable,
    input  lc3b_types::lc3b_word wr_data,
    output lc3b_types::lc3b_word rd_data_a,
    output lc3b_types::lc3b_word rd_data_b
);

    lc3b_types::lc3b_word regs [lc3b_types::reg_count];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < lc3b_types::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_enable) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // write-through so the next instruction sees the new value.
    always_comb begin
        if (wr_enable && (wr_reg == rd_reg_a)) begin
            rd_data_a = wr_data;
        end else begin
            rd_data_a = regs[rd_reg_a];
        end

        if (wr_enable && (wr_reg == rd_reg_b)) begin
            rd_data_b = wr_data;
        end else begin
            rd_data_b = regs[rd_reg_b];
        end
    end

endmodule

`default_nettype wire
